/* Bender.yml */
package:
  name: raster

sources:
  - include_dirs:
      - hw
    files:
      - hw/shape_pkg.sv
      - hw/frame_pkg.sv
      - hw/line_stepper.sv
      - hw/span_tracker.sv
      - hw/span_filler.sv
      - hw/draw_controller.sv
      - hw/frame_buffer.sv
      - hw/raster_top.sv
  - target: simulation
    include_dirs:
      - hw
    files:
      - testbench/raster_checker.sv
      - testbench/raster_monitor.sv
      - testbench/tb_raster.sv

/* hw/draw_controller.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// draw controller
// sequences clear, edges and fill per command
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps
`default_nettype none

`include "raster_settings.svh"

module draw_controller (
	input  wire                        clk,
	input  wire                        rst,
	input  wire                        start,
	input  wire shape_pkg::shape_op_e  op,
	input  wire frame_pkg::coord_t     x0,
	input  wire frame_pkg::coord_t     y0,
	input  wire frame_pkg::coord_t     x1,
	input  wire frame_pkg::coord_t     y1,
	input  wire frame_pkg::coord_t     x2,
	input  wire frame_pkg::coord_t     y2,
	input  wire frame_pkg::color_t     color,
	output logic                       busy,
	output logic                       done,
	output logic                       edge_start,
	output frame_pkg::coord_t          ax,
	output frame_pkg::coord_t          ay,
	output frame_pkg::coord_t          bx,
	output frame_pkg::coord_t          by,
	input  wire                        edge_done,
	input  wire                        pix_valid,
	input  wire frame_pkg::coord_t     px,
	input  wire frame_pkg::coord_t     py,
	output logic                       trk_clear,
	output logic                       fill_start,
	input  wire                        fill_we,
	input  wire frame_pkg::coord_t     fill_x,
	input  wire frame_pkg::coord_t     fill_y,
	input  wire                        fill_done,
	output logic                       wr_en,
	output frame_pkg::pix_addr_t       wr_addr,
	output frame_pkg::color_t          wr_data
);
	import shape_pkg::*;
	import frame_pkg::*;

	localparam pix_addr_t LAST_ADDR = pix_addr_t'(`CANVAS_PIX - 1);

	draw_state_e state;
	shape_op_e   cmd_op;
	coord_t      cx0;
	coord_t      cy0;
	coord_t      cx1;
	coord_t      cy1;
	coord_t      cx2;
	coord_t      cy2;
	color_t      cmd_color;
	pix_addr_t   clr_addr;
	logic        accept;

	assign accept = start && (state == idle);  // starts elsewhere are dropped

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state      <= idle;
			edge_start <= 1'b0;
			trk_clear  <= 1'b0;
			fill_start <= 1'b0;
			clr_addr   <= '0;
		end
		else
		begin
			edge_start <= 1'b0;
			trk_clear  <= 1'b0;
			fill_start <= 1'b0;
			case (state)
			idle:
				if (accept)
				begin
					clr_addr <= '0;
					if (op == op_clear)
						state <= clearing;
					else
					begin
						state      <= edge_a;
						edge_start <= 1'b1;
						trk_clear  <= (op == op_fill);
					end
				end
			clearing:
			begin
				clr_addr <= clr_addr + 1'b1;
				if (clr_addr == LAST_ADDR)
					state <= finish;
			end
			edge_a:
				if (edge_done)
				begin
					if (cmd_op == op_line)
						state <= finish;
					else
					begin
						state      <= edge_b;
						edge_start <= 1'b1;
					end
				end
			edge_b:
				if (edge_done)
				begin
					state      <= edge_c;
					edge_start <= 1'b1;
				end
			edge_c:
				if (edge_done)
				begin
					if (cmd_op == op_fill)
					begin
						state      <= filling;
						fill_start <= 1'b1;
					end
					else
						state <= finish;
				end
			filling:
				if (fill_done)
					state <= finish;
			default:
				state <= idle;                 // finish lasts one cycle
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			cmd_op    <= op;
			cx0       <= x0;
			cy0       <= y0;
			cx1       <= x1;
			cy1       <= y1;
			cx2       <= x2;
			cy2       <= y2;
			cmd_color <= color;
		end
	end

	// edge endpoints follow the state
	always_comb
	begin
		case (state)
		edge_b:
		begin
			ax = cx1;
			ay = cy1;
			bx = cx2;
			by = cy2;
		end
		edge_c:
		begin
			ax = cx2;
			ay = cy2;
			bx = cx0;
			by = cy0;
		end
		default:
		begin
			ax = cx0;
			ay = cy0;
			bx = cx1;
			by = cy1;
		end
		endcase
	end

	always_comb
	begin
		wr_en   = 1'b0;
		wr_addr = {py, px};
		wr_data = cmd_color;
		case (state)
		clearing:
		begin
			wr_en   = 1'b1;
			wr_addr = clr_addr;
		end
		edge_a, edge_b, edge_c:
			wr_en = pix_valid;
		filling:
		begin
			wr_en   = fill_we;
			wr_addr = {fill_y, fill_x};
		end
		default:
			wr_en = 1'b0;
		endcase
	end

	assign busy = (state != idle) && (state != finish);
	assign done = (state == finish);

endmodule

`default_nettype wire

/* hw/frame_buffer.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// frame buffer
// pixel memory, one write and one registered read
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps
`default_nettype none

`include "raster_settings.svh"

module frame_buffer (
	input  wire                        clk,
	input  wire                        wr_en,
	input  wire frame_pkg::pix_addr_t  wr_addr,
	input  wire frame_pkg::color_t     wr_data,
	input  wire frame_pkg::pix_addr_t  rd_addr,
	output frame_pkg::color_t          rd_data
);
	import frame_pkg::*;

	color_t mem [`CANVAS_PIX];

	always_ff @(posedge clk)
	begin
		if (wr_en)
			mem[wr_addr] <= wr_data;
	end

	always_ff @(posedge clk)
	begin
		rd_data <= mem[rd_addr];               // one cycle read latency
	end

endmodule

`default_nettype wire

/* hw/frame_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// frame package
// pixel coordinate, address and colour types
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

`include "raster_settings.svh"

package frame_pkg;

	// one axis position on the canvas
	typedef logic [`COORD_W-1:0] coord_t;

	// frame buffer address as {row, column}
	typedef logic [2*`COORD_W-1:0] pix_addr_t;

	// packed rgb colour
	typedef logic [`COLOR_W-1:0] color_t;

endpackage

`default_nettype wire

/* hw/line_stepper.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// line stepper
// bresenham edge walker, one pixel per clock
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps
`default_nettype none

`include "raster_settings.svh"

module line_stepper (
	input  wire                      clk,
	input  wire                      rst,
	input  wire                      edge_start,   // loads a new edge
	input  wire frame_pkg::coord_t   ax,
	input  wire frame_pkg::coord_t   ay,
	input  wire frame_pkg::coord_t   bx,
	input  wire frame_pkg::coord_t   by,
	output logic                     pix_valid,
	output frame_pkg::coord_t        px,
	output frame_pkg::coord_t        py,
	output logic                     edge_done     // with the endpoint pixel
);
	import frame_pkg::*;

	localparam int ERR_W = `COORD_W + 4;       // holds twice the largest error

	logic                    active;
	coord_t                  cur_x;
	coord_t                  cur_y;
	coord_t                  end_x;
	coord_t                  end_y;
	logic                    neg_x;
	logic                    neg_y;
	coord_t                  abs_x;
	coord_t                  abs_y;
	logic signed [ERR_W-1:0] abs_x_w;
	logic signed [ERR_W-1:0] abs_y_w;
	logic signed [ERR_W-1:0] dx;
	logic signed [ERR_W-1:0] dy;               // kept negative
	logic signed [ERR_W-1:0] err;
	logic signed [ERR_W-1:0] e2;
	logic signed [ERR_W-1:0] err_next;
	logic                    step_x;
	logic                    step_y;
	logic                    at_end;

	assign abs_x   = (bx >= ax) ? bx - ax : ax - bx;
	assign abs_y   = (by >= ay) ? by - ay : ay - by;
	assign abs_x_w = $signed({{(ERR_W-`COORD_W){1'b0}}, abs_x});
	assign abs_y_w = $signed({{(ERR_W-`COORD_W){1'b0}}, abs_y});

	assign e2     = err <<< 1;
	assign step_x = (e2 >= dy);
	assign step_y = (e2 <= dx);
	assign at_end = (cur_x == end_x) && (cur_y == end_y);

	// both steps may apply on a diagonal move
	always_comb
	begin
		err_next = err;
		if (step_x)
			err_next = err_next + dy;
		if (step_y)
			err_next = err_next + dx;
	end

	always_ff @(posedge clk)
	begin
		if (rst)
			active <= 1'b0;
		else if (edge_start)
			active <= 1'b1;
		else if (active && at_end)
			active <= 1'b0;                    // endpoint just emitted
	end

	always_ff @(posedge clk)
	begin
		if (edge_start)
		begin
			cur_x <= ax;
			cur_y <= ay;
			end_x <= bx;
			end_y <= by;
			neg_x <= (bx < ax);
			neg_y <= (by < ay);
			dx    <= abs_x_w;
			dy    <= -abs_y_w;
			err   <= abs_x_w - abs_y_w;        // dx + dy with dy negated
		end
		else if (active && !at_end)
		begin
			err <= err_next;
			if (step_x)
				cur_x <= neg_x ? cur_x - 1'b1 : cur_x + 1'b1;
			if (step_y)
				cur_y <= neg_y ? cur_y - 1'b1 : cur_y + 1'b1;
		end
	end

	assign pix_valid = active;
	assign px        = cur_x;
	assign py        = cur_y;
	assign edge_done = active && at_end;

endmodule

`default_nettype wire

/* hw/raster_settings.svh */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// raster settings
// canvas size and colour width macros
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef RASTER_SETTINGS_SVH
`define RASTER_SETTINGS_SVH

`define COORD_W 5                          // 32 pixels per side
`define COLOR_W 24                         // 8 bits each of r, g, b

// one row major address per pixel
`define CANVAS_PIX (1 << (2 * `COORD_W))

`endif

/* hw/raster_top.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// raster top
// triangle rasterizer with frame buffer read port
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps
`default_nettype none

module raster_top (
	input  wire                        clk,
	input  wire                        rst,
	input  wire                        start,
	input  wire shape_pkg::shape_op_e  op,
	input  wire frame_pkg::coord_t     x0,
	input  wire frame_pkg::coord_t     y0,
	input  wire frame_pkg::coord_t     x1,
	input  wire frame_pkg::coord_t     y1,
	input  wire frame_pkg::coord_t     x2,
	input  wire frame_pkg::coord_t     y2,
	input  wire frame_pkg::color_t     color,
	output logic                       busy,
	output logic                       done,
	input  wire frame_pkg::pix_addr_t  rd_addr,
	output frame_pkg::color_t          rd_data
);
	import frame_pkg::*;

	logic      edge_start;
	coord_t    ax;
	coord_t    ay;
	coord_t    bx;
	coord_t    by;
	logic      edge_done;
	logic      pix_valid;
	coord_t    px;
	coord_t    py;
	logic      trk_clear;
	coord_t    row;
	logic      row_valid;
	coord_t    row_min;
	coord_t    row_max;
	logic      fill_start;
	logic      fill_we;
	coord_t    fill_x;
	coord_t    fill_y;
	logic      fill_done;
	logic      wr_en;
	pix_addr_t wr_addr;
	color_t    wr_data;

	draw_controller u_ctrl (
		.clk, .rst, .start, .op,
		.x0, .y0, .x1, .y1, .x2, .y2, .color,
		.busy, .done,
		.edge_start, .ax, .ay, .bx, .by, .edge_done,
		.pix_valid, .px, .py,
		.trk_clear, .fill_start, .fill_we, .fill_x, .fill_y, .fill_done,
		.wr_en, .wr_addr, .wr_data
	);

	line_stepper u_stepper (
		.clk, .rst, .edge_start,
		.ax, .ay, .bx, .by,
		.pix_valid, .px, .py, .edge_done
	);

	span_tracker u_tracker (
		.clk, .rst, .trk_clear,
		.pix_valid, .px, .py,
		.row, .row_valid, .row_min, .row_max
	);

	span_filler u_filler (
		.clk, .rst, .fill_start,
		.row, .row_valid, .row_min, .row_max,
		.fill_we, .fill_x, .fill_y, .fill_done
	);

	frame_buffer u_fb (
		.clk, .wr_en, .wr_addr, .wr_data,
		.rd_addr, .rd_data
	);

endmodule

`default_nettype wire

/* hw/shape_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// shape package
// draw opcodes and controller states
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

package shape_pkg;

	// host command opcodes
	typedef enum logic [1:0] {
		op_clear   = 2'd0,                 // paint every pixel with color
		op_line    = 2'd1,                 // v0 to v1 only
		op_outline = 2'd2,                 // three edges
		op_fill    = 2'd3                  // three edges then row spans
	} shape_op_e;

	// draw controller sequence
	typedef enum logic [2:0] {
		idle     = 3'd0,
		clearing = 3'd1,
		edge_a   = 3'd2,                   // v0 -> v1
		edge_b   = 3'd3,                   // v1 -> v2
		edge_c   = 3'd4,                   // v2 -> v0
		filling  = 3'd5,
		finish   = 3'd6                    // done pulse
	} draw_state_e;

endpackage

`default_nettype wire

/* hw/span_filler.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// span filler
// writes every pixel of each recorded row span
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps
`default_nettype none

module span_filler (
	input  wire                      clk,
	input  wire                      rst,
	input  wire                      fill_start,
	output frame_pkg::coord_t        row,          // tracker read select
	input  wire                      row_valid,
	input  wire frame_pkg::coord_t   row_min,
	input  wire frame_pkg::coord_t   row_max,
	output logic                     fill_we,
	output frame_pkg::coord_t        fill_x,
	output frame_pkg::coord_t        fill_y,
	output logic                     fill_done
);
	import frame_pkg::*;

	localparam coord_t LAST_ROW = '1;

	logic   active;
	logic   in_span;                           // writing across the current row
	coord_t row_q;
	coord_t col_q;
	logic   last_row;
	logic   span_end;

	assign last_row  = (row_q == LAST_ROW);
	assign span_end  = in_span && (col_q == row_max);
	assign fill_done = active && last_row && (span_end || (!in_span && !row_valid));

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			active  <= 1'b0;
			in_span <= 1'b0;
			row_q   <= '0;
			col_q   <= '0;
		end
		else if (fill_start)
		begin
			active  <= 1'b1;
			in_span <= 1'b0;
			row_q   <= '0;
		end
		else if (fill_done)
		begin
			active  <= 1'b0;
			in_span <= 1'b0;
		end
		else if (active)
		begin
			if (!in_span)
			begin
				if (row_valid)
				begin
					in_span <= 1'b1;
					col_q   <= row_min;        // span starts next cycle
				end
				else
					row_q <= row_q + 1'b1;     // skip empty row
			end
			else if (span_end)
			begin
				in_span <= 1'b0;
				row_q   <= row_q + 1'b1;
			end
			else
				col_q <= col_q + 1'b1;
		end
	end

	assign row     = row_q;
	assign fill_we = active && in_span;
	assign fill_x  = col_q;
	assign fill_y  = row_q;

endmodule

`default_nettype wire

/* hw/span_tracker.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// span tracker
// per row min and max x of the edge pixels
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps
`default_nettype none

`include "raster_settings.svh"

module span_tracker (
	input  wire                      clk,
	input  wire                      rst,
	input  wire                      trk_clear,    // drops every row flag
	input  wire                      pix_valid,
	input  wire frame_pkg::coord_t   px,
	input  wire frame_pkg::coord_t   py,
	input  wire frame_pkg::coord_t   row,          // read select
	output logic                     row_valid,
	output frame_pkg::coord_t        row_min,
	output frame_pkg::coord_t        row_max
);
	import frame_pkg::*;

	localparam int ROWS = 1 << `COORD_W;

	logic [ROWS-1:0] valid_q;
	coord_t          min_q [ROWS];
	coord_t          max_q [ROWS];

	always_ff @(posedge clk)
	begin
		if (rst || trk_clear)
			valid_q <= '0;
		else if (pix_valid)
			valid_q[py] <= 1'b1;
	end

	// first pixel of a row seeds both bounds
	always_ff @(posedge clk)
	begin
		if (pix_valid)
		begin
			if (!valid_q[py] || (px < min_q[py]))
				min_q[py] <= px;
			if (!valid_q[py] || (px > max_q[py]))
				max_q[py] <= px;
		end
	end

	assign row_valid = valid_q[row];
	assign row_min   = min_q[row];
	assign row_max   = max_q[row];

endmodule

`default_nettype wire

/* src.f */
+incdir+hw
hw/shape_pkg.sv
hw/frame_pkg.sv
hw/line_stepper.sv
hw/span_tracker.sv
hw/span_filler.sv
hw/draw_controller.sv
hw/frame_buffer.sv
hw/raster_top.sv
testbench/raster_checker.sv
testbench/raster_monitor.sv
testbench/tb_raster.sv

/* testbench/raster_checker.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// raster checker
// assertions on the busy and done pulses
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps
`default_nettype none

module raster_checker (
	input wire clk,
	input wire rst,
	input wire busy,
	input wire done
);
	int fired = 0;                             // failed assertion count

	done_single: assert property (@(posedge clk) disable iff (rst) done |=> !done)
	else
	begin
		fired = fired + 1;
		$error("done stayed high for more than one cycle");
	end

	idle_after_done: assert property (@(posedge clk) disable iff (rst) done |=> !busy)
	else
	begin
		fired = fired + 1;
		$error("busy was high in the cycle after done");
	end

	done_needs_busy: assert property (@(posedge clk) disable iff (rst) done |-> $past(busy))
	else
	begin
		fired = fired + 1;
		$error("done came without busy in the cycle before");
	end

	quiet_reset: assert property (@(posedge clk) rst |=> (!busy && !done))
	else
	begin
		fired = fired + 1;
		$error("busy or done high after reset");
	end

endmodule

bind raster_top raster_checker u_checker (.clk, .rst, .busy, .done);

`default_nettype wire

/* testbench/raster_monitor.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// raster monitor
// reference image model and readback compare
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps
`default_nettype none

`include "raster_settings.svh"

module raster_monitor (
	input wire                        clk,
	input wire                        rst,
	input wire                        start,
	input wire shape_pkg::shape_op_e  op,
	input wire frame_pkg::coord_t     x0,
	input wire frame_pkg::coord_t     y0,
	input wire frame_pkg::coord_t     x1,
	input wire frame_pkg::coord_t     y1,
	input wire frame_pkg::coord_t     x2,
	input wire frame_pkg::coord_t     y2,
	input wire frame_pkg::color_t     color,
	input wire                        busy,
	input wire                        done,
	input wire                        rd_check,     // readback address is live
	input wire frame_pkg::pix_addr_t  rd_addr,
	input wire frame_pkg::color_t     rd_data
);
	import shape_pkg::*;
	import frame_pkg::*;

	localparam int SIDE = 1 << `COORD_W;

	color_t    model [`CANVAS_PIX];
	int        span_lo [SIDE];
	int        span_hi [SIDE];
	bit        span_on [SIDE];
	string     test_name = "none";
	int        accepts = 0;
	int        dones = 0;
	int        compared = 0;
	int        mismatches = 0;
	int        busy_errors = 0;
	int        tests_run = 0;
	int        tests_failed = 0;
	int        total_mismatches = 0;
	bit        pending = 1'b0;                 // command taken, done not seen yet
	logic      check_q;
	pix_addr_t addr_q;

	function automatic void put_pixel(input int x, input int y, input color_t c, input bit track);
		model[y * SIDE + x] = c;
		if (track)
		begin
			if (!span_on[y])
			begin
				span_lo[y] = x;                // first pixel of the row
				span_hi[y] = x;
				span_on[y] = 1'b1;
			end
			else
			begin
				if (x < span_lo[y])
					span_lo[y] = x;
				if (x > span_hi[y])
					span_hi[y] = x;
			end
		end
	endfunction

	// integer bresenham with the endpoint included
	function automatic void trace_edge(input int ax, input int ay, input int bx, input int by,
			input color_t c, input bit track);
		int dx;
		int dy;
		int sx;
		int sy;
		int err;
		int e2;
		int x;
		int y;
		dx  = (bx > ax) ? bx - ax : ax - bx;
		dy  = (by > ay) ? ay - by : by - ay;   // negative magnitude
		sx  = (bx >= ax) ? 1 : -1;
		sy  = (by >= ay) ? 1 : -1;
		err = dx + dy;
		x   = ax;
		y   = ay;
		put_pixel(x, y, c, track);
		while ((x != bx) || (y != by))
		begin
			e2 = 2 * err;
			if (e2 >= dy)
			begin
				err = err + dy;
				x   = x + sx;
			end
			if (e2 <= dx)
			begin
				err = err + dx;
				y   = y + sy;
			end
			put_pixel(x, y, c, track);
		end
	endfunction

	function automatic void render_command(input shape_op_e c_op, input int ax, input int ay,
			input int bx, input int by, input int cx, input int cy, input color_t c);
		int  r;
		int  x;
		bit  fill;
		fill = (c_op == op_fill);
		if (c_op == op_clear)
		begin
			for (r = 0; r < `CANVAS_PIX; r++)
				model[r] = c;
		end
		else if (c_op == op_line)
			trace_edge(ax, ay, bx, by, c, 1'b0);
		else
		begin
			for (r = 0; r < SIDE; r++)
				span_on[r] = 1'b0;
			trace_edge(ax, ay, bx, by, c, fill);
			trace_edge(bx, by, cx, cy, c, fill);
			trace_edge(cx, cy, ax, ay, c, fill);
			for (r = 0; r < SIDE; r++)
			begin
				if (fill && span_on[r])
					for (x = span_lo[r]; x <= span_hi[r]; x++)
						model[r * SIDE + x] = c;
			end
		end
	endfunction

	// a start is taken only while no command is in flight
	always @(posedge clk)
	begin
		if (rst)
			pending = 1'b0;
		else
		begin
			if (busy !== (pending && !done))
			begin
				busy_errors = busy_errors + 1;
				$display("Error: test %s busy expected %b actual %b", test_name,
					pending && !done, busy);
			end
			if (start && !pending)
			begin
				accepts = accepts + 1;
				pending = 1'b1;
				render_command(op, x0, y0, x1, y1, x2, y2, color);
			end
			if (done)
			begin
				dones   = dones + 1;
				pending = 1'b0;
			end
		end
	end

	always @(posedge clk)
	begin
		if (check_q)
		begin
			compared = compared + 1;
			if (rd_data !== model[addr_q])
			begin
				mismatches = mismatches + 1;
				$display("Error: test %s pixel (%0d,%0d) expected %06h actual %06h", test_name,
					addr_q[`COORD_W-1:0], addr_q[2*`COORD_W-1:`COORD_W], model[addr_q], rd_data);
			end
		end
		check_q <= rd_check;                   // rd_data lands one cycle later
		addr_q  <= rd_addr;
	end

	task automatic open_test(input string name);
		test_name   = name;
		accepts     = 0;
		dones       = 0;
		compared    = 0;
		mismatches  = 0;
		busy_errors = 0;
	endtask

	task automatic close_test();
		bit bad;
		bad = (mismatches != 0) || (busy_errors != 0) || (compared != `CANVAS_PIX) ||
			(accepts != dones);
		tests_run        = tests_run + 1;
		total_mismatches = total_mismatches + mismatches;
		if (compared != `CANVAS_PIX)
			$display("test %s read back %0d pixels instead of %0d", test_name, compared,
				`CANVAS_PIX);
		if (accepts != dones)
			$display("test %s saw %0d accepted starts but %0d done pulses", test_name,
				accepts, dones);
		if (bad)
		begin
			tests_failed = tests_failed + 1;
			$display("test %-18s FAIL  %0d mismatches", test_name, mismatches);
		end
		else
			$display("test %-18s ok", test_name);
	endtask

endmodule

`default_nettype wire

/* testbench/tb_raster.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// raster testbench
// draws commands and reads every frame back
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps
`default_nettype none

`include "raster_settings.svh"

module tb_raster;
	import shape_pkg::*;
	import frame_pkg::*;

	// ten tests of up to ~2300 draw and 1025 read cycles each
	localparam int CYCLE_LIMIT = 40000;

	logic      clk;
	logic      rst;
	logic      start;
	shape_op_e op;
	coord_t    x0;
	coord_t    y0;
	coord_t    x1;
	coord_t    y1;
	coord_t    x2;
	coord_t    y2;
	color_t    color;
	logic      busy;
	logic      done;
	pix_addr_t rd_addr;
	color_t    rd_data;
	logic      rd_check;
	int        cycles = 0;

	raster_top uut (
		.clk, .rst, .start, .op,
		.x0, .y0, .x1, .y1, .x2, .y2, .color,
		.busy, .done, .rd_addr, .rd_data
	);

	raster_monitor mon (
		.clk, .rst, .start, .op,
		.x0, .y0, .x1, .y1, .x2, .y2, .color,
		.busy, .done, .rd_check, .rd_addr, .rd_data
	);

	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	always @(posedge clk)
	begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT)
		begin
			$display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("sim failed");
			$finish;
		end
	end

	function automatic color_t pick_color();
		return color_t'($urandom);
	endfunction

	function automatic int pick_coord();
		return $urandom_range(31, 0);
	endfunction

	// drives the command for one cycle, leaves start low afterwards
	task automatic drive_cmd(input shape_op_e c_op, input int ax, input int ay, input int bx,
			input int by, input int cx, input int cy, input color_t c);
		@(negedge clk);
		op    = c_op;
		x0    = coord_t'(ax);
		y0    = coord_t'(ay);
		x1    = coord_t'(bx);
		y1    = coord_t'(by);
		x2    = coord_t'(cx);
		y2    = coord_t'(cy);
		color = c;
		start = 1'b1;
		@(negedge clk);
		start = 1'b0;
	endtask

	task automatic wait_done();
		do
			@(posedge clk);
		while (done !== 1'b1);
	endtask

	task automatic run_cmd(input shape_op_e c_op, input int ax, input int ay, input int bx,
			input int by, input int cx, input int cy, input color_t c);
		drive_cmd(c_op, ax, ay, bx, by, cx, cy, c);
		wait_done();
	endtask

	task automatic read_frame();
		int a;
		for (a = 0; a < `CANVAS_PIX; a++)
		begin
			@(negedge clk);
			rd_addr  = pix_addr_t'(a);
			rd_check = 1'b1;
		end
		@(negedge clk);
		rd_check = 1'b0;
		@(negedge clk);                        // last compare happens here
	endtask

	task automatic fill_test(input string name, input int ax, input int ay, input int bx,
			input int by, input int cx, input int cy);
		mon.open_test(name);
		run_cmd(op_clear, 0, 0, 0, 0, 0, 0, pick_color());
		run_cmd(op_fill, ax, ay, bx, by, cx, cy, pick_color());
		read_frame();
		mon.close_test();
	endtask

	initial
	begin
		int ends_x [8] = '{28, 20, 12, 4, 4, 12, 20, 28};
		int ends_y [8] = '{20, 28, 28, 20, 12, 4, 4, 12};
		int k;
		void'($urandom(32'hbb94));
		rst      = 1'b1;
		start    = 1'b0;
		op       = op_clear;
		x0       = '0;
		y0       = '0;
		x1       = '0;
		y1       = '0;
		x2       = '0;
		y2       = '0;
		color    = '0;
		rd_addr  = '0;
		rd_check = 1'b0;
		repeat (3) @(negedge clk);
		rst = 1'b0;

		mon.open_test("clear_random");
		run_cmd(op_clear, 0, 0, 0, 0, 0, 0, pick_color());
		read_frame();
		mon.close_test();

		// one line per octant from the centre, then the straight cases
		mon.open_test("line_octants");
		run_cmd(op_clear, 0, 0, 0, 0, 0, 0, pick_color());
		for (k = 0; k < 8; k++)
			run_cmd(op_line, 16, 16, ends_x[k], ends_y[k], 0, 0, pick_color());
		run_cmd(op_line, 2, 30, 29, 30, 0, 0, pick_color());
		run_cmd(op_line, 30, 1, 30, 29, 0, 0, pick_color());
		run_cmd(op_line, 1, 1, 1, 1, 0, 0, pick_color());
		read_frame();
		mon.close_test();

		mon.open_test("outline_tri");
		run_cmd(op_clear, 0, 0, 0, 0, 0, 0, pick_color());
		run_cmd(op_outline, pick_coord(), pick_coord(), pick_coord(), pick_coord(),
			pick_coord(), pick_coord(), pick_color());
		read_frame();
		mon.close_test();

		for (k = 0; k < 3; k++)
			fill_test($sformatf("fill_random_%0d", k), pick_coord(), pick_coord(),
				pick_coord(), pick_coord(), pick_coord(), pick_coord());
		fill_test("fill_point", 9, 21, 9, 21, 9, 21);
		fill_test("fill_collinear", 3, 5, 15, 11, 27, 17);

		// second start lands while the fill is running
		mon.open_test("start_while_busy");
		run_cmd(op_clear, 0, 0, 0, 0, 0, 0, pick_color());
		drive_cmd(op_fill, 2, 3, 29, 10, 12, 28, pick_color());
		repeat (4) @(negedge clk);
		drive_cmd(op_clear, 0, 0, 0, 0, 0, 0, pick_color());
		wait_done();
		read_frame();
		mon.close_test();

		mon.open_test("overwrite");
		run_cmd(op_outline, pick_coord(), pick_coord(), pick_coord(), pick_coord(),
			pick_coord(), pick_coord(), pick_color());
		run_cmd(op_line, pick_coord(), pick_coord(), pick_coord(), pick_coord(), 0, 0,
			pick_color());
		read_frame();
		mon.close_test();

		$display("tests %0d, failed %0d, pixel mismatches %0d, assertion failures %0d",
			mon.tests_run, mon.tests_failed, mon.total_mismatches, uut.u_checker.fired);
		if ((mon.tests_failed == 0) && (uut.u_checker.fired == 0))
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

`default_nettype wire
